// ==== Bender.yml ====
package:
  name: rename_unit

sources:
  - files:
      - rtl/rename_pkg.sv
      - rtl/commit_if.sv
      - rtl/map_table.sv
      - rtl/free_list.sv
      - rtl/retire_map.sv
      - rtl/reorder_buffer.sv
      - rtl/rename_unit.sv
  - target: test
    files:
      - test/tb_rename_unit.sv

// ==== build.f ====
rtl/rename_pkg.sv
rtl/commit_if.sv
rtl/map_table.sv
rtl/free_list.sv
rtl/retire_map.sv
rtl/reorder_buffer.sv
rtl/rename_unit.sv
test/tb_rename_unit.sv

// ==== rtl/commit_if.sv ====
`timescale 1ns/1ps

interface commit_if;
	import rename_pkg::*;

	// Retirement of the head of the reorder buffer
	logic retire_valid; // Pulses for one cycle per retired instruction
	arch_idx_t retire_arch; // Destination register of the retiring instruction
	phys_idx_t retire_phys; // Physical register that now holds its committed value

	// Register displaced from the committed map, one cycle after retirement
	logic release_valid;
	phys_idx_t release_phys;

	// Committed map snapshot handed back after a misprediction
	logic restore_valid;
	map_t restore_map;

	modport rob (
		output retire_valid, retire_arch, retire_phys
	);

	modport rrat (
		input retire_valid, retire_arch, retire_phys,
		output release_valid, release_phys, restore_valid, restore_map
	);

	modport rat (
		input restore_valid, restore_map
	);

	modport free (
		input release_valid, release_phys, restore_valid, restore_map
	);

endinterface

// ==== rtl/free_list.sv ====
`timescale 1ns/1ps

module free_list (
	input logic clock,
	input logic reset,
	input logic alloc,
	output rename_pkg::phys_idx_t alloc_phys,
	output logic empty,
	commit_if.free commit
);
	import rename_pkg::*;

	phys_mask_t free_mask; // Bit p set means physical register p can be handed out
	phys_mask_t used_mask; // Registers named by the committed snapshot

	// ########################################
	// Lowest-index allocation
	// ########################################

	always_comb begin
		alloc_phys = '0;
		// Scan from the top so the lowest set bit is the last one to win
		for (int p = phys_count - 1; p >= 0; p--) begin
			if (free_mask[p])
				alloc_phys = phys_idx_t'(p);
		end
	end

	assign empty = (free_mask == '0); // Nothing left to rename into

	// ########################################
	// Rebuild from the committed map
	// ########################################

	always_comb begin
		used_mask = '0;
		for (int a = 0; a < arch_count; a++) begin
			used_mask[commit.restore_map[a*phys_bits +: phys_bits]] = 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			free_mask <= reset_free_mask; // Identity map holds the low registers
		end else if (commit.restore_valid) begin
			// Anything the committed map does not name is free again
			free_mask <= ~used_mask;
		end else begin
			if (alloc)
				free_mask[alloc_phys] <= 1'b0; // Taken by this dispatch
			if (commit.release_valid)
				free_mask[commit.release_phys] <= 1'b1; // Displaced at retirement
		end
	end

	// A register displaced by retirement must have been live until now
	assert property (@(posedge clock) disable iff (reset)
		commit.release_valid |-> !free_mask[commit.release_phys])
		else $error("free_list: release of a register that is already free");

endmodule

// ==== rtl/map_table.sv ====
`timescale 1ns/1ps

module map_table (
	input logic clock,
	input logic reset,
	input logic dispatch_fire,
	input rename_pkg::arch_idx_t dispatch_dest,
	input rename_pkg::arch_idx_t src1,
	input rename_pkg::arch_idx_t src2,
	input rename_pkg::phys_idx_t alloc_phys,
	output rename_pkg::phys_idx_t src1_phys,
	output rename_pkg::phys_idx_t src2_phys,
	commit_if.rat commit
);
	import rename_pkg::*;

	map_t spec_map; // Speculative map, runs ahead of the committed one

	// ########################################
	// Source lookup
	// ########################################

	// Reads see the map before this cycle's own destination write lands
	assign src1_phys = spec_map[src1*phys_bits +: phys_bits];
	assign src2_phys = spec_map[src2*phys_bits +: phys_bits];

	// ########################################
	// Rename write and recovery
	// ########################################

	always_ff @(posedge clock) begin
		if (reset) begin
			spec_map <= identity_map; // Matches the committed map out of reset
		end else if (commit.restore_valid) begin
			// Everything speculative is thrown away, the committed view wins
			spec_map <= commit.restore_map;
		end else if (dispatch_fire) begin
			spec_map[dispatch_dest*phys_bits +: phys_bits] <= alloc_phys; // New producer
		end
	end

	// Dispatch is closed while the restore is in flight, so the two writes never collide
	assert property (@(posedge clock) disable iff (reset)
		!(dispatch_fire && commit.restore_valid))
		else $error("map_table: dispatch during restore");

endmodule

// ==== rtl/rename_pkg.sv ====
package rename_pkg;

	// ########################################
	// Machine sizes
	// ########################################

	localparam int arch_count = 8; // Architectural registers visible to software
	localparam int phys_count = 16; // Physical registers behind the renamer
	localparam int rob_depth = 8; // In-flight instructions held by the reorder buffer

	localparam int arch_bits = $clog2(arch_count);
	localparam int phys_bits = $clog2(phys_count);
	localparam int rob_bits = $clog2(rob_depth);

	// ########################################
	// Index and map types
	// ########################################

	typedef logic [arch_bits-1:0] arch_idx_t; // Architectural register index
	typedef logic [phys_bits-1:0] phys_idx_t; // Physical register index
	typedef logic [rob_bits-1:0] rob_idx_t; // Reorder buffer slot
	typedef logic [rob_bits:0] rob_count_t; // One extra bit so a full buffer can be counted
	typedef logic [arch_count*phys_bits-1:0] map_t; // Entry a sits at bits [a*phys_bits +: phys_bits]
	typedef logic [phys_count-1:0] phys_mask_t; // One bit per physical register

	// Out of reset architectural register a lives in physical register a
	localparam map_t identity_map = 32'h7654_3210;
	// Registers not named by the identity map start out free
	localparam phys_mask_t reset_free_mask = 16'hff00;

	// Pattern file opcodes, encoded as the ASCII letter used in the file
	typedef enum logic [7:0] {
		op_dispatch = 8'h44, // D
		op_complete = 8'h43, // C
		op_mispredict = 8'h4d, // M
		op_idle = 8'h49 // I
	} pattern_op_t;

endpackage

// ==== rtl/rename_unit.sv ====
`timescale 1ns/1ps

module rename_unit (
	input logic clock,
	input logic reset,
	input logic dispatch_valid,
	input rename_pkg::arch_idx_t dispatch_dest,
	input rename_pkg::arch_idx_t dispatch_src1,
	input rename_pkg::arch_idx_t dispatch_src2,
	output logic dispatch_ready,
	input logic complete_valid,
	input rename_pkg::rob_idx_t complete_rob,
	input logic mispredict,
	output logic rename_valid,
	output rename_pkg::phys_idx_t rename_dest_phys,
	output rename_pkg::phys_idx_t rename_src1_phys,
	output rename_pkg::phys_idx_t rename_src2_phys,
	output rename_pkg::rob_idx_t rename_rob,
	output logic retire_valid,
	output rename_pkg::arch_idx_t retire_arch,
	output rename_pkg::phys_idx_t retire_phys,
	output logic release_valid,
	output rename_pkg::phys_idx_t release_phys
);
	import rename_pkg::*;

	logic dispatch_fire; // Handshake completes this cycle
	logic list_empty;
	logic rob_full;
	phys_idx_t alloc_phys; // Lowest free register, taken on dispatch_fire
	phys_idx_t src1_phys;
	phys_idx_t src2_phys;
	rob_idx_t alloc_rob;

	commit_if commit ();

	// ########################################
	// Dispatch handshake
	// ########################################

	// Closed through the mispredict cycle and the restore cycle that follows it
	assign dispatch_ready = !list_empty && !rob_full && !mispredict && !commit.restore_valid;
	assign dispatch_fire = dispatch_valid && dispatch_ready;

	always_ff @(posedge clock) begin
		if (reset)
			rename_valid <= 1'b0;
		else
			rename_valid <= dispatch_fire; // One-cycle pulse per accepted dispatch
	end

	always_ff @(posedge clock) begin
		if (dispatch_fire) begin
			rename_dest_phys <= alloc_phys;
			rename_src1_phys <= src1_phys; // Mapping before this instruction's own write
			rename_src2_phys <= src2_phys;
			rename_rob <= alloc_rob;
		end
	end

	// ########################################
	// Instances
	// ########################################

	map_table map_table_inst (
		.clock(clock),
		.reset(reset),
		.dispatch_fire(dispatch_fire),
		.dispatch_dest(dispatch_dest),
		.src1(dispatch_src1),
		.src2(dispatch_src2),
		.alloc_phys(alloc_phys),
		.src1_phys(src1_phys),
		.src2_phys(src2_phys),
		.commit(commit.rat)
	);

	free_list free_list_inst (
		.clock(clock),
		.reset(reset),
		.alloc(dispatch_fire),
		.alloc_phys(alloc_phys),
		.empty(list_empty),
		.commit(commit.free)
	);

	retire_map retire_map_inst (
		.clock(clock),
		.reset(reset),
		.mispredict(mispredict),
		.commit(commit.rrat)
	);

	reorder_buffer reorder_buffer_inst (
		.clock(clock),
		.reset(reset),
		.alloc(dispatch_fire),
		.alloc_arch(dispatch_dest),
		.alloc_phys(alloc_phys),
		.alloc_rob(alloc_rob),
		.full(rob_full),
		.complete_valid(complete_valid),
		.complete_rob(complete_rob),
		.mispredict(mispredict),
		.commit(commit.rob)
	);

	// Retirement and release traffic is visible at the top for checking
	assign retire_valid = commit.retire_valid;
	assign retire_arch = commit.retire_arch;
	assign retire_phys = commit.retire_phys;
	assign release_valid = commit.release_valid;
	assign release_phys = commit.release_phys;

endmodule

// ==== rtl/reorder_buffer.sv ====
`timescale 1ns/1ps

module reorder_buffer (
	input logic clock,
	input logic reset,
	input logic alloc,
	input rename_pkg::arch_idx_t alloc_arch,
	input rename_pkg::phys_idx_t alloc_phys,
	output rename_pkg::rob_idx_t alloc_rob,
	output logic full,
	input logic complete_valid,
	input rename_pkg::rob_idx_t complete_rob,
	input logic mispredict,
	commit_if.rob commit
);
	import rename_pkg::*;

	rob_idx_t head; // Oldest in-flight instruction
	rob_idx_t tail; // Next slot to fill
	rob_count_t count; // Occupied slots, 0 to rob_depth
	rob_idx_t complete_offset; // Distance of the completing slot from the head

	arch_idx_t slot_arch [rob_depth]; // Destination architectural register per slot
	phys_idx_t slot_phys [rob_depth]; // Renamed destination per slot
	logic [rob_depth-1:0] slot_done; // Result produced, ready to retire

	// ########################################
	// Status and retirement
	// ########################################

	assign alloc_rob = tail;
	assign full = (count == rob_count_t'(rob_depth));

	// Retire only a finished head, and never in the cycle a mispredict flushes us
	assign commit.retire_valid = (count != '0) && slot_done[head] && !mispredict;
	assign commit.retire_arch = slot_arch[head];
	assign commit.retire_phys = slot_phys[head];

	// ########################################
	// Pointers and completion
	// ########################################

	always_ff @(posedge clock) begin
		if (reset || mispredict) begin
			// Flush drops every in-flight entry, done bits are rewritten on allocation
			head <= '0;
			tail <= '0;
			count <= '0;
			if (reset)
				slot_done <= '0;
		end else begin
			if (alloc) begin
				tail <= tail + 1'b1; // Depth is a power of two so the pointer wraps on its own
				slot_done[tail] <= 1'b0;
			end
			if (complete_valid)
				slot_done[complete_rob] <= 1'b1;
			if (commit.retire_valid)
				head <= head + 1'b1;
			if (alloc && !commit.retire_valid)
				count <= count + 1'b1;
			else if (!alloc && commit.retire_valid)
				count <= count - 1'b1;
		end
	end

	// Payload is only read while its slot is occupied
	always_ff @(posedge clock) begin
		if (alloc) begin
			slot_arch[tail] <= alloc_arch;
			slot_phys[tail] <= alloc_phys;
		end
	end

	assign complete_offset = complete_rob - head;

	// Completion has to name an instruction that is really in flight
	assert property (@(posedge clock) disable iff (reset)
		complete_valid |-> (rob_count_t'(complete_offset) < count))
		else $error("reorder_buffer: completion of an empty slot");

endmodule

// ==== rtl/retire_map.sv ====
`timescale 1ns/1ps

module retire_map (
	input logic clock,
	input logic reset,
	input logic mispredict,
	commit_if.rrat commit
);
	import rename_pkg::*;

	map_t commit_map; // Architectural state as of the last retired instruction

	// ########################################
	// Retirement update
	// ########################################

	always_ff @(posedge clock) begin
		if (reset) begin
			commit_map <= identity_map;
			commit.release_valid <= 1'b0;
		end else begin
			commit.release_valid <= commit.retire_valid; // Follows retirement by one cycle
			if (commit.retire_valid) begin
				commit_map[commit.retire_arch*phys_bits +: phys_bits] <= commit.retire_phys;
			end
		end
	end

	// Old owner of the retiring destination goes back to the free list
	always_ff @(posedge clock) begin
		if (commit.retire_valid)
			commit.release_phys <= commit_map[commit.retire_arch*phys_bits +: phys_bits];
	end

	// ########################################
	// Misprediction snapshot
	// ########################################

	always_ff @(posedge clock) begin
		if (reset)
			commit.restore_valid <= 1'b0;
		else
			commit.restore_valid <= mispredict; // Lands one cycle after the mispredict
	end

	always_ff @(posedge clock) begin
		if (mispredict)
			commit.restore_map <= commit_map; // Taken before any later retirement can change it
	end

endmodule

// ==== test/rename_patterns.txt ====
# op dest src1 src2 | ready ret_v ret_arch ret_phys | ren_v ren_dest ren_src1 ren_src2 ren_rob | rel_v rel_phys | test
# Ready and retire are checked in the line's cycle, rename and release one cycle later, x is don't care
# Dispatches out of reset take registers 8, 9, 10 and 11
D 1 1 2  1 0 x x  1 8 1 2 0  0 x  alloc_order
D 2 1 3  1 0 x x  1 9 8 3 1  0 x  alloc_order
D 3 2 1  1 0 x x  1 a 9 8 2  0 x  alloc_order
D 1 1 0  1 0 x x  1 b 8 0 3  0 x  alloc_order
# Out-of-order completion, in-order retirement with releases
C 2 x x  1 0 x x  0 x x x x  0 x  in_order_retire
C 0 x x  1 0 x x  0 x x x x  0 x  in_order_retire
I x x x  1 1 1 8  0 x x x x  1 1  in_order_retire
C 1 x x  1 0 x x  0 x x x x  0 x  in_order_retire
I x x x  1 1 2 9  0 x x x x  1 2  in_order_retire
I x x x  1 1 3 a  0 x x x x  1 3  in_order_retire
# Released registers 1 and 2 are the lowest free ones
D 4 1 3  1 0 x x  1 1 b a 4  0 x  release_reuse
D 5 4 5  1 0 x x  1 2 1 5 5  0 x  release_reuse
C 5 x x  1 0 x x  0 x x x x  0 x  release_reuse
C 3 x x  1 0 x x  0 x x x x  0 x  release_reuse
C 4 x x  1 1 1 b  0 x x x x  1 8  release_reuse
I x x x  1 1 4 1  0 x x x x  1 4  release_reuse
I x x x  1 1 5 2  0 x x x x  1 5  release_reuse
I x x x  1 0 x x  0 x x x x  0 x  release_reuse
# Nine dispatches with no retirement, the ninth is held
D 0 0 1  1 0 x x  1 3 0 b 6  0 x  rob_full
D 2 0 2  1 0 x x  1 4 3 9 7  0 x  rob_full
D 6 2 6  1 0 x x  1 5 4 6 0  0 x  rob_full
D 7 7 6  1 0 x x  1 8 7 5 1  0 x  rob_full
D 0 0 3  1 0 x x  1 c 3 a 2  0 x  rob_full
D 3 3 0  1 0 x x  1 d a c 3  0 x  rob_full
D 1 1 4  1 0 x x  1 e b 1 4  0 x  rob_full
D 5 5 7  1 0 x x  1 f 2 8 5  0 x  rob_full
D 4 0 1  0 0 x x  0 x x x x  0 x  rob_full
C 6 x x  0 0 x x  0 x x x x  0 x  rob_full
I x x x  0 1 0 3  0 x x x x  1 0  rob_full
I x x x  0 0 x x  0 x x x x  0 x  rob_full
D 4 0 1  1 0 x x  1 0 c e 6  0 x  rob_full
# Mispredict with a finished head, then recovery from the committed map
C 7 x x  0 0 x x  0 x x x x  0 x  mispredict
C 0 x x  0 1 2 4  0 x x x x  1 9  mispredict
C 1 x x  0 1 6 5  0 x x x x  1 6  mispredict
C 2 x x  1 1 7 8  0 x x x x  1 7  mispredict
M x x x  0 0 x x  0 x x x x  0 x  mispredict
D 1 1 2  0 0 x x  0 x x x x  0 x  mispredict
D 1 1 2  1 0 x x  1 0 b 4 0  0 x  mispredict
D 2 1 6  1 0 x x  1 6 0 5 1  0 x  mispredict
C 0 x x  1 0 x x  0 x x x x  0 x  mispredict
I x x x  1 1 1 0  0 x x x x  1 b  mispredict
I x x x  1 0 x x  0 x x x x  0 x  mispredict

// ==== test/tb_rename_unit.sv ====
`timescale 1ns/1ps

module tb_rename_unit;
	import rename_pkg::*;

	localparam int clock_period = 40; // ns per cycle
	localparam int field_count = 14; // Hex columns per pattern line, between opcode and name
	localparam int f_dest = 0; // Dispatch destination, or the slot for a completion
	localparam int f_src1 = 1;
	localparam int f_src2 = 2;
	localparam int f_ready = 3; // Checked in the same cycle as the inputs
	localparam int f_retire_valid = 4;
	localparam int f_retire_arch = 5;
	localparam int f_retire_phys = 6;
	localparam int f_rename_valid = 7; // Checked one cycle after the inputs
	localparam int f_rename_dest = 8;
	localparam int f_rename_src1 = 9;
	localparam int f_rename_src2 = 10;
	localparam int f_rename_rob = 11;
	localparam int f_release_valid = 12;
	localparam int f_release_phys = 13;

	logic clock, reset;
	logic dispatch_valid, dispatch_ready;
	arch_idx_t dispatch_dest, dispatch_src1, dispatch_src2;
	logic complete_valid, mispredict;
	rob_idx_t complete_rob, rename_rob;
	logic rename_valid, retire_valid, release_valid;
	phys_idx_t rename_dest_phys, rename_src1_phys, rename_src2_phys;
	arch_idx_t retire_arch;
	phys_idx_t retire_phys, release_phys;

	pattern_op_t pat_op[$]; // One entry per pattern line
	int pat_field[$]; // field_count entries per line, -1 marks a don't care
	string pat_name[$]; // Test group that owns the line
	string line_tokens[$]; // Tokens of the line being parsed
	string token_text; // Token being built one character at a time
	bit loaded = 1'b0; // Lets the watchdog size its budget

	rename_unit rename_unit_inst (.*);

	always #(clock_period / 2) clock = ~clock;

	// ########################################
	// Pattern file parsing
	// ########################################

	task automatic report_failure(input string reason);
		$display("%s", reason);
		$display("ERRORS FOUND");
		$fatal(1, "Stopping at the first failure");
	endtask

	function automatic int hex_field(input string text);
		int value;
		byte c;
		if (text == "x")
			return -1; // Don't care
		value = 0;
		for (int i = 0; i < text.len(); i++) begin
			c = text[i];
			if (c >= "0" && c <= "9")
				value = value * 16 + (c - "0");
			else if (c >= "a" && c <= "f")
				value = value * 16 + (c - "a" + 10);
			else
				return -2; // Caller reports the bad digit
		end
		return value;
	endfunction

	task automatic flush_token();
		if (token_text.len() > 0)
			line_tokens.push_back(token_text);
		token_text = "";
	endtask

	task automatic store_line(input int line_no);
		string t;
		int value;
		if (line_tokens.size() == 0)
			return; // Blank or comment-only line
		if (line_tokens.size() != field_count + 2)
			report_failure($sformatf("Pattern file line %0d has %0d fields instead of %0d",
				line_no, line_tokens.size(), field_count + 2));
		t = line_tokens[0];
		if (t != "D" && t != "C" && t != "M" && t != "I")
			report_failure($sformatf("Pattern file line %0d has an unknown opcode", line_no));
		pat_op.push_back(pattern_op_t'(t[0])); // The enum is encoded as the ASCII letter
		for (int k = 1; k <= field_count; k++) begin
			value = hex_field(line_tokens[k]);
			if (value < -1)
				report_failure($sformatf("Pattern file line %0d has a bad hex field", line_no));
			pat_field.push_back(value);
		end
		pat_name.push_back(line_tokens[field_count + 1]);
		line_tokens.delete();
	endtask

	task automatic load_patterns();
		int fd;
		int c;
		int line_no;
		bit in_comment;
		fd = $fopen("test/rename_patterns.txt", "r");
		if (fd == 0)
			report_failure("Could not open the pattern file test/rename_patterns.txt");
		line_no = 1;
		in_comment = 1'b0;
		token_text = "";
		c = $fgetc(fd);
		while (c != -1) begin
			if (c == "\n") begin
				flush_token();
				store_line(line_no);
				line_no++;
				in_comment = 1'b0;
			end else if (in_comment) begin
				// Rest of a comment is skipped
			end else if (c == "#") begin
				flush_token();
				in_comment = 1'b1;
			end else if (c == " " || c == "\t" || c == "\r") begin
				flush_token();
			end else begin
				token_text = $sformatf("%s%c", token_text, c);
			end
			c = $fgetc(fd);
		end
		flush_token();
		store_line(line_no); // Last line may lack a newline
		$fclose(fd);
		if (pat_op.size() == 0)
			report_failure("The pattern file holds no pattern lines");
	endtask

	// ########################################
	// Drive and check
	// ########################################

	function automatic int expected_value(input int n, input int f);
		return pat_field[n * field_count + f];
	endfunction

	function automatic int input_value(input int n, input int f);
		return (pat_field[n * field_count + f] < 0) ? 0 : pat_field[n * field_count + f];
	endfunction

	task automatic drive_line(input int n);
		dispatch_valid <= (pat_op[n] == op_dispatch);
		dispatch_dest <= arch_idx_t'(input_value(n, f_dest));
		dispatch_src1 <= arch_idx_t'(input_value(n, f_src1));
		dispatch_src2 <= arch_idx_t'(input_value(n, f_src2));
		complete_valid <= (pat_op[n] == op_complete);
		complete_rob <= rob_idx_t'(input_value(n, f_dest)); // Completion slot shares column one
		mispredict <= (pat_op[n] == op_mispredict);
	endtask

	task automatic drive_idle();
		dispatch_valid <= 1'b0;
		complete_valid <= 1'b0;
		mispredict <= 1'b0;
	endtask

	task automatic check_field(input string name, input int line_no, input string field,
		input int expected, input logic [7:0] actual);
		assert (expected < 0 || actual === expected[7:0])
		else report_failure($sformatf("ERROR %s (pattern %0d) %s: expected %0h, actual %0h",
			name, line_no, field, expected, actual));
	endtask

	// Handshake and retirement are combinational, so they belong to the line's own cycle
	task automatic check_this_cycle(input int n);
		check_field(pat_name[n], n + 1, "dispatch_ready", expected_value(n, f_ready), dispatch_ready);
		check_field(pat_name[n], n + 1, "retire_valid", expected_value(n, f_retire_valid), retire_valid);
		check_field(pat_name[n], n + 1, "retire_arch", expected_value(n, f_retire_arch), retire_arch);
		check_field(pat_name[n], n + 1, "retire_phys", expected_value(n, f_retire_phys), retire_phys);
	endtask

	// Rename result and release are registered and show up a cycle later
	task automatic check_next_cycle(input int n);
		check_field(pat_name[n], n + 1, "rename_valid", expected_value(n, f_rename_valid), rename_valid);
		check_field(pat_name[n], n + 1, "rename_dest_phys", expected_value(n, f_rename_dest),
			rename_dest_phys);
		check_field(pat_name[n], n + 1, "rename_src1_phys", expected_value(n, f_rename_src1),
			rename_src1_phys);
		check_field(pat_name[n], n + 1, "rename_src2_phys", expected_value(n, f_rename_src2),
			rename_src2_phys);
		check_field(pat_name[n], n + 1, "rename_rob", expected_value(n, f_rename_rob), rename_rob);
		check_field(pat_name[n], n + 1, "release_valid", expected_value(n, f_release_valid),
			release_valid);
		check_field(pat_name[n], n + 1, "release_phys", expected_value(n, f_release_phys),
			release_phys);
	endtask

	// ########################################
	// Run sequence and watchdog
	// ########################################

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		drive_idle();
		dispatch_dest = '0;
		dispatch_src1 = '0;
		dispatch_src2 = '0;
		complete_rob = '0;
		load_patterns();
		loaded = 1'b1;
		repeat (4) @(posedge clock);
		reset <= 1'b0; // Four edges have seen reset high
		@(negedge clock);
		// Idle outputs with dispatch open straight out of reset
		check_field("reset", 0, "rename_valid", 0, rename_valid);
		check_field("reset", 0, "retire_valid", 0, retire_valid);
		check_field("reset", 0, "release_valid", 0, release_valid);
		check_field("reset", 0, "dispatch_ready", 1, dispatch_ready);
		for (int n = 0; n < pat_op.size(); n++) begin
			@(posedge clock);
			drive_line(n);
			@(negedge clock); // Mid-cycle, well away from the edges
			check_this_cycle(n);
			if (n > 0)
				check_next_cycle(n - 1);
		end
		@(posedge clock);
		drive_idle();
		@(negedge clock);
		check_next_cycle(pat_op.size() - 1); // Registered results of the last line
		$display("NO ERRORS");
		$finish;
	end

	initial begin
		wait (loaded);
		#((pat_op.size() + 20) * clock_period); // Pattern lines plus slack for reset
		report_failure("Timeout, the pattern run did not finish in the expected time");
	end

endmodule
